// ==== design/id_consts.svh ====
`ifndef ID_CONSTS_SVH
`define ID_CONSTS_SVH

// field widths
`define WORD_W          32
`define REG_ADDR_W      5
`define IMM_W           16
`define SHAMT_W         5
`define OP_W            6
`define FUNCT_W         6

`define NOP_REG_ADDR    5'b00000

// primary opcodes
`define OP_SPECIAL      6'b000000
`define OP_ANDI         6'b001100
`define OP_ORI          6'b001101
`define OP_XORI         6'b001110
`define OP_LUI          6'b001111
`define OP_ADDI         6'b001000
`define OP_ADDIU        6'b001001
`define OP_SLTI         6'b001010
`define OP_SLTIU        6'b001011

// function codes under OP_SPECIAL
`define FN_AND          6'b100100
`define FN_OR           6'b100101
`define FN_XOR          6'b100110
`define FN_NOR          6'b100111
`define FN_SLL          6'b000000
`define FN_SRL          6'b000010
`define FN_SRA          6'b000011
`define FN_SLLV         6'b000100
`define FN_SRLV         6'b000110
`define FN_SRAV         6'b000111
`define FN_SLT          6'b101010
`define FN_SLTU         6'b101011
`define FN_ADD          6'b100000
`define FN_ADDU         6'b100001
`define FN_SUB          6'b100010
`define FN_SUBU         6'b100011

`endif

// ==== design/id_pkg.sv ====
`include "id_consts.svh"

package id_pkg;

    typedef logic [`WORD_W-1:0]     word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // raw MIPS32 word with the immediate in {rd, shamt, funct}
    typedef struct packed {
        logic [`OP_W-1:0]    op;
        reg_addr_t           rs;
        reg_addr_t           rt;
        reg_addr_t           rd;
        logic [`SHAMT_W-1:0] shamt;
        logic [`FUNCT_W-1:0] funct;
    } inst_t;

    typedef enum logic [7:0] {
        ALU_NOP   = 8'b0000_0000,
        ALU_AND   = 8'b0010_0100,
        ALU_OR    = 8'b0010_0101,
        ALU_XOR   = 8'b0010_0110,
        ALU_NOR   = 8'b0010_0111,
        ALU_SLL   = 8'b0111_1100,
        ALU_SRL   = 8'b0000_0010,
        ALU_SRA   = 8'b0000_0011,
        ALU_SLT   = 8'b0010_1010,
        ALU_SLTU  = 8'b0010_1011,
        ALU_ADD   = 8'b0010_0000,
        ALU_ADDU  = 8'b0010_0001,
        ALU_SUB   = 8'b0010_0010,
        ALU_SUBU  = 8'b0010_0011,
        ALU_ADDI  = 8'b0101_0101,
        ALU_ADDIU = 8'b0101_0110
    } aluop_e;

    typedef enum logic [2:0] {
        SEL_NOP   = 3'b000,
        SEL_LOGIC = 3'b001,
        SEL_SHIFT = 3'b010,
        SEL_ARITH = 3'b100   // 3'b011 left unused
    } alusel_e;

endpackage

// ==== design/fwd_if.sv ====
`timescale 1ns/1ns

// write-back info from ex and mem as levels of the current cycle
interface fwd_if;
    import id_pkg::*;

    logic      ex_wreg;
    word_t     ex_wdata;
    reg_addr_t ex_wd;
    logic      mem_wreg;
    word_t     mem_wdata;
    reg_addr_t mem_wd;

    modport source (
        output ex_wreg, ex_wdata, ex_wd,
        output mem_wreg, mem_wdata, mem_wd
    );

    modport sink (
        input ex_wreg, ex_wdata, ex_wd,
        input mem_wreg, mem_wdata, mem_wd
    );

endinterface

// ==== design/inst_decode.sv ====
`timescale 1ns/1ns
`include "id_consts.svh"

module inst_decode (
    input  id_pkg::inst_t     inst_i,
    output id_pkg::aluop_e    aluop_o,
    output id_pkg::alusel_e   alusel_o,
    output logic              wreg_o,
    output id_pkg::reg_addr_t wd_o,
    output logic              reg1_read_o,
    output logic              reg2_read_o,
    output id_pkg::reg_addr_t reg1_addr_o,
    output id_pkg::reg_addr_t reg2_addr_o,
    output id_pkg::word_t     imm_o
);
    import id_pkg::*;

    logic [`IMM_W-1:0] imm16;
    logic              r_type;   // recognised three-register form
    logic              i_type;   // recognised rs/imm -> rt form

    assign imm16 = {inst_i.rd, inst_i.shamt, inst_i.funct};

    // read ports always address rs and rt
    assign reg1_addr_o = inst_i.rs;
    assign reg2_addr_o = inst_i.rt;

    always_comb begin
        aluop_o     = ALU_NOP;
        alusel_o    = SEL_NOP;
        wreg_o      = 1'b0;
        wd_o        = inst_i.rd;
        reg1_read_o = 1'b0;
        reg2_read_o = 1'b0;
        imm_o       = '0;
        r_type      = 1'b0;
        i_type      = 1'b1;

        case (inst_i.op)
            `OP_SPECIAL: begin
                i_type = 1'b0;
                r_type = (inst_i.shamt == '0);
                case (inst_i.funct)
                    `FN_AND: begin
                        aluop_o  = ALU_AND;
                        alusel_o = SEL_LOGIC;
                    end
                    `FN_OR: begin
                        aluop_o  = ALU_OR;
                        alusel_o = SEL_LOGIC;
                    end
                    `FN_XOR: begin
                        aluop_o  = ALU_XOR;
                        alusel_o = SEL_LOGIC;
                    end
                    `FN_NOR: begin
                        aluop_o  = ALU_NOR;
                        alusel_o = SEL_LOGIC;
                    end
                    `FN_SLLV: begin
                        aluop_o  = ALU_SLL;
                        alusel_o = SEL_SHIFT;
                    end
                    `FN_SRLV: begin
                        aluop_o  = ALU_SRL;
                        alusel_o = SEL_SHIFT;
                    end
                    `FN_SRAV: begin
                        aluop_o  = ALU_SRA;
                        alusel_o = SEL_SHIFT;
                    end
                    `FN_SLT: begin
                        aluop_o  = ALU_SLT;
                        alusel_o = SEL_ARITH;
                    end
                    `FN_SLTU: begin
                        aluop_o  = ALU_SLTU;
                        alusel_o = SEL_ARITH;
                    end
                    `FN_ADD: begin
                        aluop_o  = ALU_ADD;
                        alusel_o = SEL_ARITH;
                    end
                    `FN_ADDU: begin
                        aluop_o  = ALU_ADDU;
                        alusel_o = SEL_ARITH;
                    end
                    `FN_SUB: begin
                        aluop_o  = ALU_SUB;
                        alusel_o = SEL_ARITH;
                    end
                    `FN_SUBU: begin
                        aluop_o  = ALU_SUBU;
                        alusel_o = SEL_ARITH;
                    end
                    default: r_type = 1'b0;
                endcase
                if (!r_type) begin   // nonzero shamt or dropped funct
                    aluop_o  = ALU_NOP;
                    alusel_o = SEL_NOP;
                end
            end
            `OP_ANDI: begin
                aluop_o  = ALU_AND;
                alusel_o = SEL_LOGIC;
                imm_o    = {{(`WORD_W-`IMM_W){1'b0}}, imm16};
            end
            `OP_ORI: begin
                aluop_o  = ALU_OR;
                alusel_o = SEL_LOGIC;
                imm_o    = {{(`WORD_W-`IMM_W){1'b0}}, imm16};
            end
            `OP_XORI: begin
                aluop_o  = ALU_XOR;
                alusel_o = SEL_LOGIC;
                imm_o    = {{(`WORD_W-`IMM_W){1'b0}}, imm16};
            end
            `OP_LUI: begin   // or with upper-half constant
                aluop_o  = ALU_OR;
                alusel_o = SEL_LOGIC;
                imm_o    = {imm16, {(`WORD_W-`IMM_W){1'b0}}};
            end
            `OP_ADDI: begin
                aluop_o  = ALU_ADDI;
                alusel_o = SEL_ARITH;
                imm_o    = {{(`WORD_W-`IMM_W){imm16[`IMM_W-1]}}, imm16};
            end
            `OP_ADDIU: begin
                aluop_o  = ALU_ADDIU;
                alusel_o = SEL_ARITH;
                imm_o    = {{(`WORD_W-`IMM_W){imm16[`IMM_W-1]}}, imm16};
            end
            `OP_SLTI: begin
                aluop_o  = ALU_SLT;
                alusel_o = SEL_ARITH;
                imm_o    = {{(`WORD_W-`IMM_W){imm16[`IMM_W-1]}}, imm16};
            end
            `OP_SLTIU: begin
                aluop_o  = ALU_SLTU;
                alusel_o = SEL_ARITH;
                imm_o    = {{(`WORD_W-`IMM_W){imm16[`IMM_W-1]}}, imm16};
            end
            default: i_type = 1'b0;
        endcase

        if (r_type) begin
            wreg_o      = 1'b1;
            reg1_read_o = 1'b1;
            reg2_read_o = 1'b1;
        end
        if (i_type) begin
            wreg_o      = 1'b1;
            reg1_read_o = 1'b1;
            wd_o        = inst_i.rt;
        end

        // shift by shamt overrides the above so 32'h0 is sll r0
        if ({inst_i.op, inst_i.rs} == '0 && (inst_i.funct == `FN_SLL ||
                inst_i.funct == `FN_SRL || inst_i.funct == `FN_SRA)) begin
            case (inst_i.funct)
                `FN_SRL: aluop_o = ALU_SRL;
                `FN_SRA: aluop_o = ALU_SRA;
                default: aluop_o = ALU_SLL;
            endcase
            alusel_o    = SEL_SHIFT;
            wreg_o      = 1'b1;
            wd_o        = inst_i.rd;
            reg1_read_o = 1'b0;
            reg2_read_o = 1'b1;
            imm_o       = {{(`WORD_W-`SHAMT_W){1'b0}}, inst_i.shamt};
        end
    end

endmodule

// ==== design/operand_fwd.sv ====
`timescale 1ns/1ns

module operand_fwd (
    input  logic              read_i,
    input  id_pkg::reg_addr_t addr_i,
    input  id_pkg::word_t     rf_data_i,
    input  id_pkg::word_t     imm_i,
    fwd_if.sink               fwd,
    output id_pkg::word_t     operand_o
);

    logic ex_hit;
    logic mem_hit;

    // r0 is not filtered out here
    assign ex_hit  = fwd.ex_wreg && (fwd.ex_wd == addr_i);
    assign mem_hit = fwd.mem_wreg && (fwd.mem_wd == addr_i);

    always_comb begin
        if (!read_i) begin
            operand_o = imm_i;   // immediate never forwarded
        end else if (ex_hit) begin
            operand_o = fwd.ex_wdata;   // youngest result first
        end else if (mem_hit) begin
            operand_o = fwd.mem_wdata;
        end else begin
            operand_o = rf_data_i;
        end
    end

endmodule

// ==== design/id_stage.sv ====
`timescale 1ns/1ns
`include "id_consts.svh"

module id_stage (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  id_pkg::inst_t     inst_i,
    input  id_pkg::word_t     reg1_data_i,
    input  id_pkg::word_t     reg2_data_i,
    input  logic              ex_wreg_i,
    input  id_pkg::word_t     ex_wdata_i,
    input  id_pkg::reg_addr_t ex_wd_i,
    input  logic              mem_wreg_i,
    input  id_pkg::word_t     mem_wdata_i,
    input  id_pkg::reg_addr_t mem_wd_i,
    output logic              reg1_read_o,
    output logic              reg2_read_o,
    output id_pkg::reg_addr_t reg1_addr_o,
    output id_pkg::reg_addr_t reg2_addr_o,
    output id_pkg::aluop_e    aluop_o,
    output id_pkg::alusel_e   alusel_o,
    output id_pkg::word_t     reg1_o,
    output id_pkg::word_t     reg2_o,
    output id_pkg::reg_addr_t wd_o,
    output logic              wreg_o
);
    import id_pkg::*;

    aluop_e    dec_aluop;
    alusel_e   dec_alusel;
    logic      dec_wreg;
    reg_addr_t dec_wd;
    word_t     dec_imm;
    word_t     opnd1;
    word_t     opnd2;

    fwd_if i_fwd ();

    // stage ports drive the source side
    assign i_fwd.ex_wreg   = ex_wreg_i;
    assign i_fwd.ex_wdata  = ex_wdata_i;
    assign i_fwd.ex_wd     = ex_wd_i;
    assign i_fwd.mem_wreg  = mem_wreg_i;
    assign i_fwd.mem_wdata = mem_wdata_i;
    assign i_fwd.mem_wd    = mem_wd_i;

    inst_decode i_decode (
        .inst_i      (inst_i),
        .aluop_o     (dec_aluop),
        .alusel_o    (dec_alusel),
        .wreg_o      (dec_wreg),
        .wd_o        (dec_wd),
        .reg1_read_o (reg1_read_o),
        .reg2_read_o (reg2_read_o),
        .reg1_addr_o (reg1_addr_o),
        .reg2_addr_o (reg2_addr_o),
        .imm_o       (dec_imm)
    );

    operand_fwd i_opnd1 (
        .read_i    (reg1_read_o),
        .addr_i    (reg1_addr_o),
        .rf_data_i (reg1_data_i),
        .imm_i     (dec_imm),
        .fwd       (i_fwd.sink),
        .operand_o (opnd1)
    );

    operand_fwd i_opnd2 (
        .read_i    (reg2_read_o),
        .addr_i    (reg2_addr_o),
        .rf_data_i (reg2_data_i),
        .imm_i     (dec_imm),
        .fwd       (i_fwd.sink),
        .operand_o (opnd2)
    );

    // ID/EX register
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            aluop_o  <= ALU_NOP;
            alusel_o <= SEL_NOP;
            wreg_o   <= 1'b0;
            wd_o     <= `NOP_REG_ADDR;
            reg1_o   <= '0;
            reg2_o   <= '0;
        end else begin
            aluop_o  <= dec_aluop;
            alusel_o <= dec_alusel;
            wreg_o   <= dec_wreg;
            wd_o     <= dec_wd;
            reg1_o   <= opnd1;
            reg2_o   <= opnd2;
        end
    end

endmodule

// ==== sim/id_stage_checker.sv ====
`timescale 1ns/1ns

module id_stage_checker (
    input logic              clk_i,
    input logic              rst_n_i,
    input id_pkg::inst_t     inst_i,
    input id_pkg::reg_addr_t reg1_addr_i,
    input id_pkg::reg_addr_t reg2_addr_i,
    input id_pkg::aluop_e    aluop_i,
    input id_pkg::alusel_e   alusel_i,
    input logic              wreg_i
);
    import id_pkg::*;

    // a reset edge leaves a bubble in ID/EX
    reset_bubble: assert property (@(posedge clk_i)
        !rst_n_i |=> (!wreg_i && aluop_i == ALU_NOP))
        else $error("ID/EX not cleared by the reset edge");

    read_fields: assert property (@(posedge clk_i)
        reg1_addr_i == inst_i.rs && reg2_addr_i == inst_i.rt)   // ports follow rs and rt
        else $error("register-file read address differs from the rs/rt field");

    write_class: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wreg_i |-> alusel_i != SEL_NOP)
        else $error("write enable set on a NOP result class");

endmodule

// ==== sim/id_stage_tb.sv ====
`timescale 1ns/1ns
`include "id_consts.svh"

module id_stage_tb;
    import id_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int N_TESTS      = 30;
    localparam int TEST_CYCLES  = 2;   // drive edge, capture edge
    localparam int MAX_CYCLES   = 2 * N_TESTS * TEST_CYCLES + RESET_CYCLES;
    localparam int EXT_ZERO     = 0;
    localparam int EXT_UPPER    = 1;
    localparam int EXT_SIGN     = 2;
    localparam int SRC_RF       = 0;
    localparam int SRC_EX       = 1;
    localparam int SRC_MEM      = 2;

    logic      clk_i, rst_n_i, ex_wreg_i, mem_wreg_i;
    logic      reg1_read_o, reg2_read_o, wreg_o;
    inst_t     inst_i;
    word_t     reg1_data_i, reg2_data_i, ex_wdata_i, mem_wdata_i, reg1_o, reg2_o;
    reg_addr_t ex_wd_i, mem_wd_i, reg1_addr_o, reg2_addr_o, wd_o;
    aluop_e    aluop_o;
    alusel_e   alusel_o;

    integer seed = 41552;
    int     cycle_cnt = 0;
    string  test_name;
    word_t  rf1, rf2, ex_data, mem_data;   // data sent with the current instruction

    id_stage i_id_stage (.*);

    bind id_stage id_stage_checker i_checker (
        .clk_i, .rst_n_i, .inst_i, .reg1_addr_i(reg1_addr_o), .reg2_addr_i(reg2_addr_o),
        .aluop_i(aluop_o), .alusel_i(alusel_o), .wreg_i(wreg_o));

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: tests still running after %0d cycles", cycle_cnt);
            abort_run();
        end
    end

    function automatic inst_t make_rtype(reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
                                         logic [4:0] shamt, logic [5:0] funct);
        return {`OP_SPECIAL, rs, rt, rd, shamt, funct};
    endfunction

    function automatic word_t extend_imm(int kind, logic [15:0] imm);
        case (kind)
            EXT_UPPER: return {imm, 16'h0000};
            EXT_SIGN:  return {{16{imm[15]}}, imm};
            default:   return {16'h0000, imm};
        endcase
    endfunction

    task automatic abort_run();
        $display("STATUS: FAIL");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_word(string what, word_t exp, word_t act);
        if (act !== exp) begin
            $display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_addr(string what, reg_addr_t exp, reg_addr_t act);
        if (act !== exp) begin
            $display("ERR %s %s: expected %0d, actual %0d", test_name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_aluop(string what, aluop_e exp, aluop_e act);
        if (act !== exp) begin
            $display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_alusel(string what, alusel_e exp, alusel_e act);
        if (act !== exp) begin
            $display("ERR %s %s: expected %b, actual %b", test_name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_bit(string what, logic exp, logic act);
        if (act !== exp) begin
            $display("ERR %s %s: expected %b, actual %b", test_name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic drive(inst_t w, logic ex_en, reg_addr_t ex_wd,
                         logic mem_en, reg_addr_t mem_wd);
        rf1      = $random(seed);
        rf2      = $random(seed);
        ex_data  = $random(seed);
        mem_data = $random(seed);
        @(posedge clk_i);
        inst_i      <= w;
        reg1_data_i <= rf1;
        reg2_data_i <= rf2;
        ex_wreg_i   <= ex_en;
        ex_wd_i     <= ex_wd;
        ex_wdata_i  <= ex_data;
        mem_wreg_i  <= mem_en;
        mem_wd_i    <= mem_wd;
        mem_wdata_i <= mem_data;
    endtask

    // read side is combinational so look at it mid-cycle
    task automatic check_reads(inst_t w, logic r1, logic r2);
        @(negedge clk_i);
        check_bit("reg1_read", r1, reg1_read_o);
        check_bit("reg2_read", r2, reg2_read_o);
        check_addr("reg1_addr", w.rs, reg1_addr_o);
        check_addr("reg2_addr", w.rt, reg2_addr_o);
    endtask

    task automatic check_regs(aluop_e op, alusel_e sel, logic wr, reg_addr_t wd,
                              word_t d1, word_t d2);
        @(posedge clk_i);   // ID/EX capture
        @(negedge clk_i);
        check_aluop("aluop", op, aluop_o);
        check_alusel("alusel", sel, alusel_o);
        check_bit("wreg", wr, wreg_o);
        check_addr("wd", wd, wd_o);
        check_word("reg1", d1, reg1_o);
        check_word("reg2", d2, reg2_o);
    endtask

    task automatic test_reset();
        test_name = "reset";
        repeat (RESET_CYCLES - 2) @(posedge clk_i);
        check_regs(ALU_NOP, SEL_NOP, 1'b0, `NOP_REG_ADDR, '0, '0);
        @(posedge clk_i);
        rst_n_i <= 1'b1;
    endtask

    task automatic test_rtype(string name, logic [5:0] funct, aluop_e op, alusel_e sel);
        inst_t w;
        test_name = name;
        w = make_rtype(5'd3, 5'd7, 5'd12, 5'd0, funct);
        drive(w, 1'b0, 5'd0, 1'b0, 5'd0);
        check_reads(w, 1'b1, 1'b1);
        check_regs(op, sel, 1'b1, 5'd12, rf1, rf2);
    endtask

    // rt is the destination and operand 2 the extended immediate
    task automatic test_itype(string name, logic [5:0] opc, logic [15:0] imm, int kind,
                              aluop_e op, alusel_e sel);
        inst_t w;
        test_name = name;
        w = {opc, 5'd5, 5'd6, imm};
        drive(w, 1'b0, 5'd0, 1'b0, 5'd0);
        check_reads(w, 1'b1, 1'b0);
        check_regs(op, sel, 1'b1, 5'd6, rf1, extend_imm(kind, imm));
    endtask

    task automatic test_shift_imm(string name, logic [5:0] funct, reg_addr_t rt,
                                  reg_addr_t rd, logic [4:0] shamt, aluop_e op);
        inst_t w;
        test_name = name;
        w = make_rtype(5'd0, rt, rd, shamt, funct);
        drive(w, 1'b0, 5'd0, 1'b0, 5'd0);
        check_reads(w, 1'b0, 1'b1);
        check_regs(op, SEL_SHIFT, 1'b1, rd, {27'd0, shamt}, rf2);
    endtask

    // add r11, r9, r10 while ex and mem write back
    task automatic test_forward(string name, logic ex_en, reg_addr_t ex_wd,
                                logic mem_en, reg_addr_t mem_wd, int src);
        inst_t w;
        word_t exp1;
        test_name = name;
        w = make_rtype(5'd9, 5'd10, 5'd11, 5'd0, `FN_ADD);
        drive(w, ex_en, ex_wd, mem_en, mem_wd);
        exp1 = (src == SRC_EX) ? ex_data : (src == SRC_MEM) ? mem_data : rf1;
        check_reads(w, 1'b1, 1'b1);
        check_regs(ALU_ADD, SEL_ARITH, 1'b1, 5'd11, exp1, rf2);
    endtask

    task automatic test_fwd_imm();
        inst_t w;
        test_name = "fwd imm";
        w = {`OP_ORI, 5'd9, 5'd10, 16'h00f0};
        drive(w, 1'b1, 5'd10, 1'b1, 5'd10);   // both stages write rt
        check_reads(w, 1'b1, 1'b0);
        check_regs(ALU_OR, SEL_LOGIC, 1'b1, 5'd10, rf1, 32'h0000_00f0);
    endtask

    task automatic test_unknown();
        inst_t w;
        test_name = "mult";
        w = make_rtype(5'd4, 5'd5, 5'd6, 5'd0, 6'b011000);
        drive(w, 1'b0, 5'd0, 1'b0, 5'd0);
        check_reads(w, 1'b0, 1'b0);
        check_regs(ALU_NOP, SEL_NOP, 1'b0, 5'd6, '0, '0);
    endtask

    initial begin
        rst_n_i     <= 1'b0;
        inst_i      <= make_rtype(5'd1, 5'd2, 5'd3, 5'd0, `FN_ADD);
        reg1_data_i <= $random(seed);   // nonzero data so the reset clear shows
        reg2_data_i <= $random(seed);
        ex_wreg_i   <= 1'b0;
        ex_wdata_i  <= '0;
        ex_wd_i     <= '0;
        mem_wreg_i  <= 1'b0;
        mem_wdata_i <= '0;
        mem_wd_i    <= '0;
        test_reset();
        test_rtype("and", `FN_AND, ALU_AND, SEL_LOGIC);
        test_rtype("or", `FN_OR, ALU_OR, SEL_LOGIC);
        test_rtype("xor", `FN_XOR, ALU_XOR, SEL_LOGIC);
        test_rtype("nor", `FN_NOR, ALU_NOR, SEL_LOGIC);
        test_rtype("slt", `FN_SLT, ALU_SLT, SEL_ARITH);
        test_rtype("sltu", `FN_SLTU, ALU_SLTU, SEL_ARITH);
        test_rtype("add", `FN_ADD, ALU_ADD, SEL_ARITH);
        test_rtype("addu", `FN_ADDU, ALU_ADDU, SEL_ARITH);
        test_rtype("sub", `FN_SUB, ALU_SUB, SEL_ARITH);
        test_rtype("subu", `FN_SUBU, ALU_SUBU, SEL_ARITH);
        test_rtype("sllv", `FN_SLLV, ALU_SLL, SEL_SHIFT);
        test_rtype("srlv", `FN_SRLV, ALU_SRL, SEL_SHIFT);
        test_rtype("srav", `FN_SRAV, ALU_SRA, SEL_SHIFT);
        test_itype("andi", `OP_ANDI, 16'h8a5c, EXT_ZERO, ALU_AND, SEL_LOGIC);
        test_itype("ori", `OP_ORI, 16'hf00f, EXT_ZERO, ALU_OR, SEL_LOGIC);
        test_itype("xori", `OP_XORI, 16'h9bcd, EXT_ZERO, ALU_XOR, SEL_LOGIC);
        test_itype("lui", `OP_LUI, 16'hbeef, EXT_UPPER, ALU_OR, SEL_LOGIC);
        test_itype("addi", `OP_ADDI, 16'hfff0, EXT_SIGN, ALU_ADDI, SEL_ARITH);
        test_itype("addiu", `OP_ADDIU, 16'h1234, EXT_SIGN, ALU_ADDIU, SEL_ARITH);
        test_itype("slti", `OP_SLTI, 16'h8001, EXT_SIGN, ALU_SLT, SEL_ARITH);
        test_itype("sltiu", `OP_SLTIU, 16'hc000, EXT_SIGN, ALU_SLTU, SEL_ARITH);
        test_shift_imm("sll", `FN_SLL, 5'd8, 5'd14, 5'd5, ALU_SLL);
        test_shift_imm("srl", `FN_SRL, 5'd8, 5'd15, 5'd31, ALU_SRL);
        test_shift_imm("sra", `FN_SRA, 5'd9, 5'd16, 5'd1, ALU_SRA);
        test_shift_imm("zero word", `FN_SLL, 5'd0, 5'd0, 5'd0, ALU_SLL);
        test_forward("fwd ex over mem", 1'b1, 5'd9, 1'b1, 5'd9, SRC_EX);
        test_forward("fwd mem", 1'b0, 5'd9, 1'b1, 5'd9, SRC_MEM);
        test_forward("fwd miss", 1'b1, 5'd20, 1'b1, 5'd21, SRC_RF);
        test_fwd_imm();
        test_unknown();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+design
design/id_pkg.sv
design/fwd_if.sv
design/inst_decode.sv
design/operand_fwd.sv
design/id_stage.sv
sim/id_stage_checker.sv
sim/id_stage_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the ID stage testbench, the log decides the verdict
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ns --top-module id_stage_tb \
    -f vlog.f -o sim_id_stage \
    && ./obj_dir/sim_id_stage > sim.log 2>&1 \
    || echo "STATUS: FAIL" >> sim.log

cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1 || exit 0
